// File: tb.f
+incdir+common
common/cache_pkg.sv
cache/cache_plru.sv
cache/cache_store.sv
cache/cache_ctrl.sv
logic/cache_top.sv
bench/mem_model.sv
bench/tb_cache.sv

// File: Makefile
# Verilator build and run of the cache testbench

VERILATOR ?= verilator
TOP       ?= tb_cache
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST)) common/cache_config.svh

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/tb_cache.sv
// testbench for cache_top, random loads and stores over a few conflicting tags
// unwritten memory is expected to hold the same fill pattern as mem_model
`timescale 1ns/1ps
`include "cache_config.svh"

module tb_cache;

    localparam logic [31:0] RAND_SEED  = 32'h3a6a_9230;
    localparam int          WAIT_LIMIT = 200;   // cycles, far above a dirty miss
    localparam int          RANDOM_OPS = 400;

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   cpu_valid;
    cache_pkg::cpu_req_t    cpu_req;
    logic                   cpu_ready;
    logic                   cpu_resp_valid;
    cache_pkg::cpu_resp_t   cpu_resp;
    logic                   mem_rd_req;
    cache_pkg::mem_rd_req_t mem_rd_addr;
    logic                   mem_rd_rdy;
    logic                   mem_ret_valid;
    cache_pkg::line_t       mem_ret_data;
    logic                   mem_wr_req;
    cache_pkg::mem_wr_req_t mem_wr;
    logic                   mem_wr_rdy;

    integer                 seed;
    logic [7:0]             shadow [logic [31:0]];   // bytes written so far
    int                     mem_req_cycles = 0;
    int                     wb_cycles = 0;
    logic [31:0]            rdata;
    int                     latency;
    logic [31:0]            pending_addr;   // address of the request in flight

    cache_top u_cache_top (
        .clk, .reset, .cpu_valid, .cpu_req, .cpu_ready, .cpu_resp_valid, .cpu_resp,
        .mem_rd_req, .mem_rd_addr, .mem_rd_rdy, .mem_ret_valid, .mem_ret_data,
        .mem_wr_req, .mem_wr, .mem_wr_rdy
    );

    mem_model #(.SEED(RAND_SEED)) u_mem_model (
        .clk, .reset, .mem_rd_req, .mem_rd_addr, .mem_rd_rdy, .mem_ret_valid,
        .mem_ret_data, .mem_wr_req, .mem_wr, .mem_wr_rdy
    );

    always #10 clk = ~clk;

    task automatic stop_on_failure(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        stop_on_failure($sformatf("Error: %s = 0x%h, expected 0x%h", name, got, expected));
    endtask

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'h6b4f_21d3;
    endfunction

    function automatic logic [31:0] shadow_word(input logic [31:0] addr);
        logic [31:0] base;
        logic [31:0] word;
        base = {addr[31:2], 2'b00};
        word = fill_word(base);
        for (int b = 0; b < 4; b++) begin
            if (shadow.exists(base + 32'(b))) begin
                word[8*b +: 8] = shadow[base + 32'(b)];
            end
        end
        return word;
    endfunction

    task automatic write_shadow(input logic [31:0] addr, input logic [3:0] wstrb,
                                input logic [31:0] wdata);
        for (int b = 0; b < 4; b++) begin
            if (wstrb[b]) begin
                shadow[{addr[31:2], 2'b00} + 32'(b)] = wdata[8*b +: 8];
            end
        end
    endtask

    // six tags over four sets, so ways get evicted
    function automatic logic [31:0] pick_addr();
        logic [23:0] tag;
        logic [3:0]  index;
        logic [1:0]  word;
        tag   = 24'h00_0100 + 24'($unsigned($random(seed)) % 6);
        index = 4'($unsigned($random(seed)) % 4);
        word  = 2'($random(seed));
        return {tag, index, word, 2'b00};
    endfunction

    // one request from drive to response, loads checked against the shadow
    task automatic do_access(input logic op, input logic [31:0] addr, input logic [3:0] wstrb,
                             input logic [31:0] wdata, output logic [31:0] data_out,
                             output int cycles);
        logic [31:0] expected;
        int          waited;
        @(negedge clk);
        cpu_valid          = 1'b1;
        cpu_req.op         = op;
        cpu_req.addr.raw   = addr;
        cpu_req.wstrb      = wstrb;
        cpu_req.wdata      = wdata;
        waited             = 0;
        while (!cpu_ready) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_on_failure("timed out waiting for cpu_ready");
            end
        end
        expected     = shadow_word(addr);   // accepted at the next rising edge
        pending_addr = addr;
        if (op) begin
            write_shadow(addr, wstrb, wdata);
        end
        @(negedge clk);
        cpu_valid = 1'b0;
        cycles    = 1;
        waited    = 0;
        while (!cpu_resp_valid) begin
            @(negedge clk);
            cycles++;
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_on_failure("timed out waiting for cpu_resp_valid");
            end
        end
        data_out = cpu_resp.rdata;
        if (!op) begin
            a_load_data: assert (cpu_resp.rdata == expected)
                else report_mismatch("cpu_resp.rdata", cpu_resp.rdata, expected);
        end
    endtask

    // refills fetch the pending line, write-back lines carry the latest stored bytes
    always @(negedge clk) begin : wb_monitor
        logic [31:0] expected;
        if (!reset && (mem_rd_req || mem_wr_req)) begin
            mem_req_cycles++;
        end
        if (!reset && mem_rd_req) begin
            a_rd_addr: assert (mem_rd_addr.line_addr == pending_addr[31:`CACHE_OFFSET_BITS])
                else report_mismatch("mem_rd_addr.line_addr", 32'(mem_rd_addr.line_addr),
                                     32'(pending_addr[31:`CACHE_OFFSET_BITS]));
        end
        if (!reset && mem_wr_req) begin
            wb_cycles++;
            for (int w = 0; w < `CACHE_LINE_WORDS; w++) begin
                expected = shadow_word({mem_wr.line_addr, 2'(w), 2'b00});
                a_wb_data: assert (mem_wr.data[w] == expected)
                    else report_mismatch("mem_wr.data", mem_wr.data[w], expected);
            end
        end
    end

    initial begin : stimulus
        logic [31:0] old_word;
        logic [31:0] merged;
        logic [31:0] addr;
        logic [3:0]  strb;
        logic [31:0] data;
        int          req_before;
        int          wb_before;
        seed      = RAND_SEED;
        reset     = 1'b1;
        cpu_valid = 1'b0;
        cpu_req   = '0;
        repeat (10) @(negedge clk);
        reset = 1'b0;

        @(negedge clk);
        a_rst_ready: assert (cpu_ready) else stop_on_failure("cpu_ready is low after reset");
        a_rst_resp: assert (!cpu_resp_valid)
            else stop_on_failure("cpu_resp_valid is high after reset");
        a_rst_mem: assert (!mem_rd_req && !mem_wr_req)
            else stop_on_failure("a memory request is high after reset");

        // partial store merges into the old word
        addr = {24'h00_0200, 4'h5, 4'h8};
        strb = 4'b0110;
        data = $random(seed);
        do_access(1'b0, addr, 4'h0, 32'h0, old_word, latency);
        do_access(1'b1, addr, strb, data, rdata, latency);
        do_access(1'b0, addr, 4'h0, 32'h0, rdata, latency);
        for (int b = 0; b < 4; b++) begin
            merged[8*b +: 8] = strb[b] ? data[8*b +: 8] : old_word[8*b +: 8];
        end
        a_partial: assert (rdata == merged) else report_mismatch("cpu_resp.rdata", rdata, merged);

        // a repeated load hits in one cycle without memory traffic
        addr = {24'h00_0300, 4'h7, 4'h4};
        do_access(1'b0, addr, 4'h0, 32'h0, rdata, latency);
        req_before = mem_req_cycles;
        do_access(1'b0, addr, 4'h0, 32'h0, rdata, latency);
        a_hit_latency: assert (latency == 1)
            else stop_on_failure($sformatf("repeated load took %0d cycles", latency));
        a_hit_no_mem: assert (mem_req_cycles == req_before)
            else stop_on_failure("repeated load made a memory request");

        // five dirty lines in one four-way set
        wb_before = wb_cycles;
        for (int i = 0; i < 5; i++) begin
            addr = {24'h00_0a00 + 24'(i), 4'h9, 2'(i), 2'b00};
            do_access(1'b1, addr, 4'hf, $random(seed), rdata, latency);
        end
        for (int i = 0; i < 5; i++) begin
            addr = {24'h00_0a00 + 24'(i), 4'h9, 2'(i), 2'b00};
            do_access(1'b0, addr, 4'h0, 32'h0, rdata, latency);
        end
        a_evicted: assert (wb_cycles > wb_before)
            else stop_on_failure("no dirty line was written back");

        for (int n = 0; n < RANDOM_OPS; n++) begin
            addr = pick_addr();
            do_access(1'($random(seed)), addr, 4'($random(seed)), $random(seed), rdata, latency);
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: bench/mem_model.sv
// line-wide memory model with random ready and return delays up to MEM_MAX_DELAY
// unwritten lines read back a fill pattern built from the whole word address
`timescale 1ns/1ps
`include "cache_config.svh"

module mem_model #(
    parameter logic [31:0] SEED = 32'h3a6a_9230
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   mem_rd_req,
    input  cache_pkg::mem_rd_req_t mem_rd_addr,
    output logic                   mem_rd_rdy,
    output logic                   mem_ret_valid,
    output cache_pkg::line_t       mem_ret_data,
    input  logic                   mem_wr_req,
    input  cache_pkg::mem_wr_req_t mem_wr,
    output logic                   mem_wr_rdy
);

    typedef logic [`CACHE_TAG_BITS+`CACHE_INDEX_BITS-1:0] line_addr_t;

    integer           seed;
    int               rd_wait;
    int               wr_wait;
    int               ret_wait;
    logic             ret_pending;   // refill accepted, data not sent
    line_addr_t       ret_addr;
    cache_pkg::line_t backing [line_addr_t];

    initial seed = SEED;

    function automatic int random_delay();
        return int'($unsigned($random(seed)) % (`MEM_MAX_DELAY + 1));
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'h6b4f_21d3;
    endfunction

    function automatic cache_pkg::line_t read_line(input line_addr_t line_addr);
        cache_pkg::line_t line;
        if (backing.exists(line_addr)) begin
            return backing[line_addr];
        end
        for (int w = 0; w < `CACHE_LINE_WORDS; w++) begin
            line[w] = fill_word({line_addr, 2'(w), 2'b00});
        end
        return line;
    endfunction

    always @(negedge clk) begin
        mem_rd_rdy    <= 1'b0;
        mem_wr_rdy    <= 1'b0;
        mem_ret_valid <= 1'b0;
        if (reset) begin
            rd_wait      <= 0;
            wr_wait      <= 0;
            ret_wait     <= 0;
            ret_pending  <= 1'b0;
            mem_ret_data <= '0;
        end else begin
            if (mem_wr_req && !mem_wr_rdy) begin
                if (wr_wait == 0) begin
                    mem_wr_rdy                <= 1'b1;
                    backing[mem_wr.line_addr] = mem_wr.data;   // write lands with the ready
                    wr_wait                   <= random_delay();
                end else begin
                    wr_wait <= wr_wait - 1;
                end
            end
            if (mem_rd_req && !mem_rd_rdy && !ret_pending) begin
                if (rd_wait == 0) begin
                    mem_rd_rdy  <= 1'b1;
                    ret_pending <= 1'b1;
                    ret_addr    <= mem_rd_addr.line_addr;
                    rd_wait     <= random_delay();
                end else begin
                    rd_wait <= rd_wait - 1;
                end
            end
            if (ret_pending) begin
                if (ret_wait == 0) begin
                    mem_ret_valid <= 1'b1;
                    mem_ret_data  <= read_line(ret_addr);
                    ret_pending   <= 1'b0;
                    ret_wait      <= random_delay();
                end else begin
                    ret_wait <= ret_wait - 1;
                end
            end
        end
    end

endmodule

// File: logic/cache_top.sv
// four-way set-associative write-back cache, blocking, one request at a time
// the memory port moves whole lines addressed by tag and index
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cpu_valid,
    input  cache_pkg::cpu_req_t    cpu_req,
    output logic                   cpu_ready,
    output logic                   cpu_resp_valid,
    output cache_pkg::cpu_resp_t   cpu_resp,
    output logic                   mem_rd_req,
    output cache_pkg::mem_rd_req_t mem_rd_addr,
    input  logic                   mem_rd_rdy,
    input  logic                   mem_ret_valid,
    input  cache_pkg::line_t       mem_ret_data,
    output logic                   mem_wr_req,
    output cache_pkg::mem_wr_req_t mem_wr,
    input  logic                   mem_wr_rdy
);

    logic [`CACHE_INDEX_BITS-1:0]            rd_index;
    logic [`CACHE_INDEX_BITS-1:0]            wr_index;
    cache_pkg::tag_entry_t [`CACHE_WAYS-1:0] rd_entries;
    cache_pkg::line_t [`CACHE_WAYS-1:0]      rd_lines;
    logic [`CACHE_WAYS-1:0]                  wr_en;
    cache_pkg::tag_entry_t                   wr_entry;
    cache_pkg::line_t                        wr_line;
    logic                                    plru_access;
    logic [`CACHE_INDEX_BITS-1:0]            plru_set;
    cache_pkg::way_sel_t                     plru_way;
    cache_pkg::way_sel_t                     victim;

    cache_ctrl u_cache_ctrl (
        .clk, .reset, .cpu_valid, .cpu_req, .cpu_ready, .cpu_resp_valid, .cpu_resp,
        .rd_index, .rd_entries, .rd_lines, .wr_index, .wr_en, .wr_entry, .wr_line,
        .plru_access, .plru_set, .plru_way, .victim,
        .mem_rd_req, .mem_rd_addr, .mem_rd_rdy, .mem_ret_valid, .mem_ret_data,
        .mem_wr_req, .mem_wr, .mem_wr_rdy
    );

    cache_store u_cache_store (
        .clk, .reset, .rd_index, .rd_entries, .rd_lines,
        .wr_index, .wr_en, .wr_entry, .wr_line
    );

    cache_plru u_cache_plru (
        .clk,
        .reset,
        .access    (plru_access),
        .set       (plru_set),
        .way       (plru_way),
        .query_set (plru_set),   // victim is asked for the pending request's set
        .victim    (victim)
    );

endmodule

// File: cache/cache_ctrl.sv
// blocking controller, one request in flight; a hit answers one cycle after acceptance
// misses write back a dirty victim, refill the line, then look up again
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_ctrl (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    cpu_valid,
    input  cache_pkg::cpu_req_t                     cpu_req,
    output logic                                    cpu_ready,
    output logic                                    cpu_resp_valid,
    output cache_pkg::cpu_resp_t                    cpu_resp,
    output logic [`CACHE_INDEX_BITS-1:0]            rd_index,
    input  cache_pkg::tag_entry_t [`CACHE_WAYS-1:0] rd_entries,
    input  cache_pkg::line_t [`CACHE_WAYS-1:0]      rd_lines,
    output logic [`CACHE_INDEX_BITS-1:0]            wr_index,
    output logic [`CACHE_WAYS-1:0]                  wr_en,
    output cache_pkg::tag_entry_t                   wr_entry,
    output cache_pkg::line_t                        wr_line,
    output logic                                    plru_access,
    output logic [`CACHE_INDEX_BITS-1:0]            plru_set,
    output cache_pkg::way_sel_t                     plru_way,
    input  cache_pkg::way_sel_t                     victim,
    output logic                                    mem_rd_req,
    output cache_pkg::mem_rd_req_t                  mem_rd_addr,
    input  logic                                    mem_rd_rdy,
    input  logic                                    mem_ret_valid,
    input  cache_pkg::line_t                        mem_ret_data,
    output logic                                    mem_wr_req,
    output cache_pkg::mem_wr_req_t                  mem_wr,
    input  logic                                    mem_wr_rdy
);

    typedef enum logic [2:0] {
        IDLE, LOOKUP, MISS_DIRTY, WRITEBACK, MISS_CLEAN, REFILL, REFILL_DONE
    } state_t;

    state_t                                 state;
    state_t                                 state_next;
    cache_pkg::cpu_req_t                    req_q;
    cache_pkg::way_sel_t                    victim_q;
    cache_pkg::line_t                       refill_q;
    logic [`CACHE_WAYS-1:0]                 hit;
    logic                                   hit_any;
    cache_pkg::way_sel_t                    hit_way;
    logic [$clog2(`CACHE_LINE_WORDS)-1:0]   word_sel;
    logic                                   accept;

    // byte-wise merge of the store word into a line
    function automatic cache_pkg::line_t merge_store(input cache_pkg::line_t line,
                                                     input cache_pkg::cpu_req_t req);
        cache_pkg::line_t                     merged;
        logic [$clog2(`CACHE_LINE_WORDS)-1:0] word;
        merged = line;
        word   = req.addr.f.offset[`CACHE_OFFSET_BITS-1:2];
        for (int b = 0; b < 4; b++) begin
            if (req.wstrb[b]) begin
                merged[word][8*b +: 8] = req.wdata[8*b +: 8];
            end
        end
        return merged;
    endfunction

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            hit[w] = rd_entries[w].valid && (rd_entries[w].tag == req_q.addr.f.tag);
            if (hit[w]) begin
                hit_way = cache_pkg::way_sel_t'(w);
            end
        end
    end

    assign hit_any        = |hit;
    assign word_sel       = req_q.addr.f.offset[`CACHE_OFFSET_BITS-1:2];
    assign cpu_resp_valid = (state == LOOKUP) && hit_any;
    assign cpu_ready      = (state == IDLE) || cpu_resp_valid;   // back-to-back on a hit
    assign accept         = cpu_valid && cpu_ready;
    assign cpu_resp.rdata = rd_lines[hit_way][word_sel];

    assign rd_index = cpu_ready ? cpu_req.addr.f.index : req_q.addr.f.index;
    assign wr_index = req_q.addr.f.index;

    // fill way on refill, hit way on a store hit
    always_comb begin
        wr_en          = '0;
        wr_entry.valid = 1'b1;
        wr_entry.dirty = 1'b1;
        wr_entry.tag   = req_q.addr.f.tag;
        wr_line        = merge_store(rd_lines[hit_way], req_q);
        if (state == REFILL_DONE) begin
            wr_en[victim_q] = 1'b1;
            wr_entry.dirty  = req_q.op;   // store already merged into refill
            wr_line         = refill_q;
        end else if (cpu_resp_valid && req_q.op) begin
            wr_en = hit;
        end
    end

    assign plru_access = cpu_resp_valid || (state == REFILL_DONE);
    assign plru_set    = req_q.addr.f.index;   // also the victim query set
    assign plru_way    = (state == REFILL_DONE) ? victim_q : hit_way;

    assign mem_rd_req            = (state == MISS_CLEAN);
    assign mem_rd_addr.line_addr = {req_q.addr.f.tag, req_q.addr.f.index};
    assign mem_wr_req            = (state == WRITEBACK);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= cpu_req;
        end
        if (state == LOOKUP && !hit_any) begin
            victim_q <= victim;
        end
        if (state == MISS_DIRTY) begin   // store outputs still hold this set
            mem_wr.line_addr <= {rd_entries[victim_q].tag, req_q.addr.f.index};
            mem_wr.data      <= rd_lines[victim_q];
        end
        if (state == REFILL && mem_ret_valid) begin
            refill_q <= req_q.op ? merge_store(mem_ret_data, req_q) : mem_ret_data;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    state_next = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit_any) begin
                    state_next = accept ? LOOKUP : IDLE;
                end else if (rd_entries[victim].valid && rd_entries[victim].dirty) begin
                    state_next = MISS_DIRTY;
                end else begin
                    state_next = MISS_CLEAN;
                end
            end
            MISS_DIRTY: state_next = WRITEBACK;
            WRITEBACK: begin
                if (mem_wr_rdy) begin
                    state_next = MISS_CLEAN;
                end
            end
            MISS_CLEAN: begin
                if (mem_rd_rdy) begin
                    state_next = REFILL;
                end
            end
            REFILL: begin
                if (mem_ret_valid) begin
                    state_next = REFILL_DONE;
                end
            end
            REFILL_DONE: state_next = LOOKUP;   // re-read of the filled set
            default: state_next = IDLE;
        endcase
    end

    // a line lives in one way of its set at most
    a_hit_onehot: assert property (@(posedge clk) disable iff (reset)
        state == LOOKUP |-> $onehot0(hit));

endmodule

// File: cache/cache_store.sv
// tag and data store, one-cycle synchronous read of all ways of a set
// a write to the set being read is forwarded to the read outputs
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_store (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic [`CACHE_INDEX_BITS-1:0]              rd_index,
    output cache_pkg::tag_entry_t [`CACHE_WAYS-1:0]   rd_entries,
    output cache_pkg::line_t [`CACHE_WAYS-1:0]        rd_lines,
    input  logic [`CACHE_INDEX_BITS-1:0]              wr_index,
    input  logic [`CACHE_WAYS-1:0]                    wr_en,
    input  cache_pkg::tag_entry_t                     wr_entry,
    input  cache_pkg::line_t                          wr_line
);

    logic [`CACHE_SETS-1:0][`CACHE_WAYS-1:0] valid_q;
    logic [`CACHE_TAG_BITS:0]                meta_mem [`CACHE_WAYS][`CACHE_SETS]; // {dirty, tag}
    cache_pkg::line_t                        line_mem [`CACHE_WAYS][`CACHE_SETS];

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                if (wr_en[w]) begin
                    valid_q[wr_index][w] <= wr_entry.valid;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (wr_en[w]) begin
                meta_mem[w][wr_index] <= {wr_entry.dirty, wr_entry.tag};
                line_mem[w][wr_index] <= wr_line;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (wr_en[w] && wr_index == rd_index) begin
                rd_entries[w] <= wr_entry;   // write-first on same set
                rd_lines[w]   <= wr_line;
            end else begin
                rd_entries[w].valid                    <= valid_q[rd_index][w];
                {rd_entries[w].dirty, rd_entries[w].tag} <= meta_mem[w][rd_index];
                rd_lines[w]                            <= line_mem[w][rd_index];
            end
        end
    end

    // the controller fills or updates a single way at a time
    a_one_way_write: assert property (@(posedge clk) disable iff (reset) $onehot0(wr_en));

endmodule

// File: cache/cache_plru.sv
// tree pseudo-LRU, three bits per set, so four ways only
// victim follows the tree bits combinationally for query_set
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_plru (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         access,
    input  logic [`CACHE_INDEX_BITS-1:0] set,
    input  cache_pkg::way_sel_t          way,
    input  logic [`CACHE_INDEX_BITS-1:0] query_set,
    output cache_pkg::way_sel_t          victim
);

    logic [`CACHE_SETS-1:0][2:0] tree_q;   // [0] root, [1] ways 0/1, [2] ways 2/3
    logic [2:0]                  query_bits;

    assign query_bits = tree_q[query_set];

    always_comb begin
        if (query_bits[0]) begin
            victim = {1'b1, query_bits[2]};   // right half
        end else begin
            victim = {1'b0, query_bits[1]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tree_q <= '0;
        end else if (access) begin
            tree_q[set][0] <= ~way[1];         // root points to the other half
            if (way[1]) begin
                tree_q[set][2] <= ~way[0];
            end else begin
                tree_q[set][1] <= ~way[0];
            end
        end
    end

endmodule

// File: common/cache_pkg.sv
// shared cache types, sized from the config header
// line addresses on the memory port drop the byte offset
`include "cache_config.svh"

package cache_pkg;

    typedef logic [$clog2(`CACHE_WAYS)-1:0] way_sel_t;

    typedef struct packed {
        logic [`CACHE_TAG_BITS-1:0]    tag;
        logic [`CACHE_INDEX_BITS-1:0]  index;
        logic [`CACHE_OFFSET_BITS-1:0] offset;
    } addr_fields_t;

    typedef union packed {
        logic [31:0]  raw;
        addr_fields_t f;
    } cache_addr_u;

    typedef logic [`CACHE_LINE_WORDS-1:0][31:0] line_t;

    typedef struct packed {
        logic        op;        // 0 load, 1 store
        cache_addr_u addr;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic [31:0] rdata;
    } cpu_resp_t;

    typedef struct packed {
        logic                       valid;
        logic                       dirty;
        logic [`CACHE_TAG_BITS-1:0] tag;
    } tag_entry_t;

    typedef struct packed {
        logic [`CACHE_TAG_BITS+`CACHE_INDEX_BITS-1:0] line_addr;
    } mem_rd_req_t;

    typedef struct packed {
        logic [`CACHE_TAG_BITS+`CACHE_INDEX_BITS-1:0] line_addr;
        line_t                                        data;
    } mem_wr_req_t;

endpackage

// File: common/cache_config.svh
// cache geometry and memory model limits
// the offset, index and tag widths must agree with the word, set and address sizes
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// geometry
`define CACHE_WAYS        4     // tree pseudo-LRU assumes exactly four
`define CACHE_LINE_WORDS  4     // 32-bit words per line
`define CACHE_SETS        16

// address split of a 32-bit byte address
`define CACHE_OFFSET_BITS 4     // log2 of line bytes
`define CACHE_INDEX_BITS  4     // log2 of sets
`define CACHE_TAG_BITS    24    // 32 - index - offset

// longest random ready or return delay of the memory model, in cycles
`define MEM_MAX_DELAY     6

`endif
